//--- daq_cfg.svh
`ifndef DAQ_CFG_SVH
`define DAQ_CFG_SVH

// frame geometry
`define DAQ_CH_W    12  // bits per channel sample
`define DAQ_NCH     16  // channels in one group word
`define DAQ_NGRP    6   // group words per adc frame

// top address bit picks the ping-pong half
`define DAQ_RAM_AW  10
`define DAQ_SMP_W   6   // samp_max width

// wishbone port
`define DAQ_WB_AW   16
`define DAQ_WB_DW   16

`endif

//--- daq_pkg.sv
`include "daq_cfg.svh"

package daq_pkg;

	typedef logic [`DAQ_CH_W-1:0]          sample_t;
	typedef logic [`DAQ_NCH*`DAQ_CH_W-1:0] group_t;
	typedef logic [`DAQ_RAM_AW-1:0]        ram_addr_t;
	typedef logic [`DAQ_SMP_W-1:0]         smp_cnt_t;
	typedef logic [23:0]                   l1a_cnt_t;
	typedef logic [11:0]                   mtch_cnt_t;
	typedef logic [3:0]                    ovlp_cnt_t;
	typedef logic [`DAQ_WB_DW-1:0]         wb_dat_t;

	// {buf, multi_ovlp, ovrlap, ovlp_cnt, mtch_cnt, l1a_cnt}
	typedef logic [42:0] header_t;

	typedef enum logic [1:0] {
		LD_IDLE,
		LD_WAIT_FRAME,
		LD_WRITE,
		LD_DONE
	} load_state_t;

	typedef enum logic [1:0] {
		WB_IDLE,
		WB_RAM_WAIT,
		WB_ACK
	} wb_state_t;

endpackage

//--- event_control.sv
`timescale 1ns/1ns

module event_control import daq_pkg::*; (
	input  logic       WRCLK,
	input  logic       srst,
	input  logic       l1a,
	input  logic       l1a_match,
	input  logic       done,
	input  logic       rel,
	input  logic       rel_buf,
	output logic       start,
	output logic       buf_sel,
	output logic       hdr_push,
	output header_t    hdr_in,
	output logic [1:0] buf_busy
);

	l1a_cnt_t  l1a_cnt;
	mtch_cnt_t mtch_cnt;
	l1a_cnt_t  l1a_cnt_nxt;
	mtch_cnt_t mtch_cnt_nxt;
	l1a_cnt_t  hdr_l1a;     // counts frozen at event start
	mtch_cnt_t hdr_mtch;
	ovlp_cnt_t ovlp_cnt;
	ovlp_cnt_t ovlp_nxt;
	logic      active;      // capture running
	logic      next_buf;
	logic      evt_start;
	logic      evt_end;

	assign l1a_cnt_nxt  = l1a ? l1a_cnt + 1'b1 : l1a_cnt;
	assign mtch_cnt_nxt = l1a_match ? mtch_cnt + 1'b1 : mtch_cnt;
	assign evt_start    = l1a_match & ~active & ~buf_busy[next_buf];
	assign evt_end      = active & done;
	assign buf_sel      = next_buf;

	// overlap count with this cycle's match, stops at 15
	always_comb begin
		ovlp_nxt = ovlp_cnt;
		if (active && l1a_match && ovlp_cnt != 4'hf)
			ovlp_nxt = ovlp_cnt + 1'b1;
	end

	always_ff @(posedge WRCLK or posedge srst) begin
		if (srst) begin
			l1a_cnt  <= '0;
			mtch_cnt <= '0;
		end else begin
			l1a_cnt  <= l1a_cnt_nxt;
			mtch_cnt <= mtch_cnt_nxt;
		end
	end

	////////////////////////////////////////
	// capture and buffer tracking
	always_ff @(posedge WRCLK or posedge srst) begin
		if (srst) begin
			active   <= 1'b0;
			next_buf <= 1'b0;
			buf_busy <= 2'b00;
			start    <= 1'b0;
			hdr_push <= 1'b0;
			ovlp_cnt <= '0;
		end else begin
			start    <= evt_start;
			hdr_push <= evt_end;
			if (evt_start) begin
				active             <= 1'b1;
				buf_busy[next_buf] <= 1'b1;
			end else if (evt_end) begin
				active   <= 1'b0;
				next_buf <= ~next_buf;   // ping-pong
				ovlp_cnt <= '0;
			end else begin
				ovlp_cnt <= ovlp_nxt;
			end
			if (rel)
				buf_busy[rel_buf] <= 1'b0;   // host popped its header
		end
	end

	always_ff @(posedge WRCLK) begin
		if (evt_start) begin
			hdr_l1a  <= l1a_cnt_nxt;
			hdr_mtch <= mtch_cnt_nxt;
		end
		if (evt_end)
			hdr_in <= {next_buf, ovlp_nxt > 4'h1, ovlp_nxt != 4'h0, ovlp_nxt,
				hdr_mtch, hdr_l1a};
	end

endmodule

//--- frame_loader.sv
`timescale 1ns/1ns
`include "daq_cfg.svh"

module frame_loader import daq_pkg::*; (
	input  logic      WRCLK,
	input  logic      srst,
	input  logic      start,
	input  logic      buf_sel,
	input  smp_cnt_t  samp_max,
	input  logic      adc_valid,
	input  group_t    adc_g1,
	input  group_t    adc_g2,
	input  group_t    adc_g3,
	input  group_t    adc_g4,
	input  group_t    adc_g5,
	input  group_t    adc_g6,
	output logic      done,
	output logic      ld_req,
	output ram_addr_t ld_addr,
	output group_t    ld_data
);

	typedef logic [`DAQ_RAM_AW-2:0] offs_t;

	load_state_t state;
	group_t      grp [`DAQ_NGRP];   // latched frame
	logic [2:0]  sel;               // group selector
	smp_cnt_t    sample;            // sample within event
	logic        cur_buf;
	logic        last_grp;
	logic        latch;
	offs_t       offs;

	assign last_grp = (sel == 3'(`DAQ_NGRP - 1));

	// take a frame while waiting or right in the start cycle
	assign latch = adc_valid &&
		((state == LD_WAIT_FRAME) || (state == LD_IDLE && start));

	// word offset inside the half is 6*sample + group
	assign offs    = offs_t'(sample * `DAQ_NGRP + sel);
	assign ld_req  = (state == LD_WRITE);
	assign ld_addr = {cur_buf, offs};
	assign ld_data = grp[sel];
	assign done    = ld_req && last_grp && (sample == samp_max);

	////////////////////////////////////////
	// load FSM
	always_ff @(posedge WRCLK or posedge srst) begin
		if (srst) begin
			state   <= LD_IDLE;
			sel     <= '0;
			sample  <= '0;
			cur_buf <= 1'b0;
		end else begin
			case (state)
				LD_IDLE: begin
					if (start) begin
						cur_buf <= buf_sel;
						sample  <= '0;
						state   <= latch ? LD_WRITE : LD_WAIT_FRAME;
					end
				end
				LD_WAIT_FRAME: begin
					if (latch)
						state <= LD_WRITE;
				end
				LD_WRITE: begin
					if (last_grp) begin
						sel <= '0;
						if (sample == samp_max) begin
							state <= LD_DONE;
						end else begin
							sample <= sample + 1'b1;
							state  <= LD_WAIT_FRAME;
						end
					end else begin
						sel <= sel + 1'b1;
					end
				end
				LD_DONE: state <= LD_IDLE;   // one idle cycle between events
				default: state <= LD_IDLE;
			endcase
		end
	end

	always_ff @(posedge WRCLK) begin
		if (latch) begin
			grp[0] <= adc_g1;
			grp[1] <= adc_g2;
			grp[2] <= adc_g3;
			grp[3] <= adc_g4;
			grp[4] <= adc_g5;
			grp[5] <= adc_g6;
		end
	end

endmodule

//--- sample_ram.sv
`timescale 1ns/1ns
`include "daq_cfg.svh"

module sample_ram import daq_pkg::*; (
	input  logic      WRCLK,
	input  logic      we,
	input  ram_addr_t addr,
	input  group_t    wdata,
	output group_t    rdata
);

	// two halves of 512 words each
	group_t mem [2**`DAQ_RAM_AW];

	////////////////////////////////////////
	// single port with registered read
	always_ff @(posedge WRCLK) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];   // old data on a write cycle
	end

endmodule

//--- ram_arbiter.sv
`timescale 1ns/1ns

module ram_arbiter import daq_pkg::*; (
	input  logic      WRCLK,
	input  logic      srst,
	input  logic      ld_req,
	input  ram_addr_t ld_addr,
	input  group_t    ld_data,
	input  logic      rd_req,
	input  ram_addr_t rd_addr,
	output logic      rd_gnt,
	output group_t    rd_data,
	output logic      ram_we,
	output ram_addr_t ram_addr,
	output group_t    ram_wdata,
	input  group_t    ram_rdata
);

	logic   gnt_d;     // read issued last cycle
	group_t rd_hold;

	assign rd_gnt    = rd_req & ~ld_req;   // loader always wins
	assign ram_we    = ld_req;
	assign ram_addr  = ld_req ? ld_addr : rd_addr;
	assign ram_wdata = ld_data;

	// fresh word right after the grant, held while the loader writes
	assign rd_data = gnt_d ? ram_rdata : rd_hold;

	always_ff @(posedge WRCLK or posedge srst) begin
		if (srst)
			gnt_d <= 1'b0;
		else
			gnt_d <= rd_gnt;
	end

	always_ff @(posedge WRCLK) begin
		if (gnt_d)
			rd_hold <= ram_rdata;
	end

endmodule

//--- header_fifo.sv
`timescale 1ns/1ns

module header_fifo import daq_pkg::*; (
	input  logic    WRCLK,
	input  logic    srst,
	input  logic    push,
	input  header_t din,
	input  logic    pop,
	output header_t dout,
	output logic    empty,
	output logic    full
);

	header_t    mem [2];
	logic       wr_ptr;
	logic       rd_ptr;
	logic [1:0] count;
	logic       do_push;
	logic       do_pop;

	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;
	assign empty   = (count == 2'd0);
	assign full    = (count == 2'd2);
	assign dout    = mem[rd_ptr];   // show-ahead

	always_ff @(posedge WRCLK or posedge srst) begin
		if (srst) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end else begin
			if (do_push)
				wr_ptr <= ~wr_ptr;
			if (do_pop)
				rd_ptr <= ~rd_ptr;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge WRCLK) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

endmodule

//--- wb_readout.sv
`timescale 1ns/1ns
`include "daq_cfg.svh"

module wb_readout import daq_pkg::*; (
	input  logic                  WRCLK,
	input  logic                  srst,
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  logic [`DAQ_WB_AW-1:0] wb_adr,
	input  wb_dat_t               wb_dat_w,
	input  logic                  rd_gnt,
	input  group_t                rd_data,
	input  header_t               hdr_out,
	input  logic                  hdr_empty,
	input  logic [1:0]            buf_busy,
	output wb_dat_t               wb_dat_r,
	output logic                  wb_ack,
	output logic                  rd_req,
	output ram_addr_t             rd_addr,
	output logic                  hdr_pop,
	output logic                  rel,
	output logic                  rel_buf
);

	localparam logic [1:0] SP_SAMPLE = 2'b00;
	localparam logic [1:0] SP_REG    = 2'b01;

	wb_state_t   state;
	logic        req;        // new transfer seen in idle
	logic        is_smp;
	logic        is_reg;
	logic [3:0]  chan;
	logic        granted;    // ram word arrives this cycle
	logic [47:0] hdr_ext;
	sample_t     smp;
	wb_dat_t     reg_dat;

	assign req     = (state == WB_IDLE) && wb_cyc && wb_stb;
	assign is_smp  = (wb_adr[15:14] == SP_SAMPLE);
	assign is_reg  = (wb_adr[15:14] == SP_REG);
	assign hdr_ext = {5'b0, hdr_out};
	assign smp     = rd_data[chan*`DAQ_CH_W +: `DAQ_CH_W];
	assign wb_ack  = (state == WB_ACK);

	// writing 1 to bit 0 of register 4 pops the header
	assign hdr_pop = req && is_reg && wb_we && (wb_adr[3:0] == 4'd4) &&
		wb_dat_w[0] && !hdr_empty;
	assign rel     = hdr_pop;
	assign rel_buf = hdr_out[42];   // buffer index of the popped header

	////////////////////////////////////////
	// register read mux
	always_comb begin
		case (wb_adr[3:0])
			4'd0:    reg_dat = wb_dat_t'({buf_busy, hdr_empty});   // status
			4'd1:    reg_dat = hdr_ext[15:0];
			4'd2:    reg_dat = hdr_ext[31:16];
			4'd3:    reg_dat = hdr_ext[47:32];
			default: reg_dat = '0;
		endcase
	end

	always_ff @(posedge WRCLK or posedge srst) begin
		if (srst) begin
			state   <= WB_IDLE;
			rd_req  <= 1'b0;
			granted <= 1'b0;
		end else begin
			case (state)
				WB_IDLE: begin
					if (req) begin
						if (is_smp && !wb_we) begin
							rd_req <= 1'b1;
							state  <= WB_RAM_WAIT;
						end else begin
							state <= WB_ACK;   // registers and ignored writes
						end
					end
				end
				WB_RAM_WAIT: begin
					if (rd_gnt) begin
						rd_req  <= 1'b0;
						granted <= 1'b1;
					end
					if (granted) begin
						granted <= 1'b0;
						state   <= WB_ACK;
					end
				end
				WB_ACK:  state <= WB_IDLE;
				default: state <= WB_IDLE;
			endcase
		end
	end

	always_ff @(posedge WRCLK) begin
		if (req) begin
			rd_addr  <= wb_adr[13:4];
			chan     <= wb_adr[3:0];
			wb_dat_r <= (is_reg && !wb_we) ? reg_dat : '0;
		end
		if (state == WB_RAM_WAIT && granted)
			wb_dat_r <= wb_dat_t'(smp);   // zero-extended channel
	end

endmodule

//--- sample_buffer_top.sv
`timescale 1ns/1ns
`include "daq_cfg.svh"

module sample_buffer_top import daq_pkg::*; (
	input  logic                  WRCLK,
	input  logic                  srst,
	input  logic                  l1a,
	input  logic                  l1a_match,
	input  logic                  adc_valid,
	input  group_t                adc_g1,
	input  group_t                adc_g2,
	input  group_t                adc_g3,
	input  group_t                adc_g4,
	input  group_t                adc_g5,
	input  group_t                adc_g6,
	input  smp_cnt_t              samp_max,
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  logic [`DAQ_WB_AW-1:0] wb_adr,
	input  wb_dat_t               wb_dat_w,
	output wb_dat_t               wb_dat_r,
	output logic                  wb_ack
);

	// event control and loader
	logic       start;
	logic       buf_sel;
	logic       done;
	logic       hdr_push;
	header_t    hdr_in;
	logic [1:0] buf_busy;
	logic       rel;
	logic       rel_buf;

	// ram access
	logic      ld_req;
	ram_addr_t ld_addr;
	group_t    ld_data;
	logic      rd_req;
	ram_addr_t rd_addr;
	logic      rd_gnt;
	group_t    rd_data;
	logic      ram_we;
	ram_addr_t ram_addr;
	group_t    ram_wdata;
	group_t    ram_rdata;

	// header path
	header_t hdr_out;
	logic    hdr_empty;
	logic    hdr_pop;

	event_control u_evt (
		.WRCLK(WRCLK), .srst(srst), .l1a(l1a), .l1a_match(l1a_match),
		.done(done), .rel(rel), .rel_buf(rel_buf), .start(start),
		.buf_sel(buf_sel), .hdr_push(hdr_push), .hdr_in(hdr_in),
		.buf_busy(buf_busy)
	);

	frame_loader u_ld (
		.WRCLK(WRCLK), .srst(srst), .start(start), .buf_sel(buf_sel),
		.samp_max(samp_max), .adc_valid(adc_valid),
		.adc_g1(adc_g1), .adc_g2(adc_g2), .adc_g3(adc_g3),
		.adc_g4(adc_g4), .adc_g5(adc_g5), .adc_g6(adc_g6),
		.done(done), .ld_req(ld_req), .ld_addr(ld_addr), .ld_data(ld_data)
	);

	ram_arbiter u_arb (
		.WRCLK(WRCLK), .srst(srst), .ld_req(ld_req), .ld_addr(ld_addr),
		.ld_data(ld_data), .rd_req(rd_req), .rd_addr(rd_addr),
		.rd_gnt(rd_gnt), .rd_data(rd_data), .ram_we(ram_we),
		.ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
	);

	sample_ram u_ram (
		.WRCLK(WRCLK), .we(ram_we), .addr(ram_addr), .wdata(ram_wdata),
		.rdata(ram_rdata)
	);

	// two buffers so the fifo cannot overflow
	header_fifo u_hdr (
		.WRCLK(WRCLK), .srst(srst), .push(hdr_push), .din(hdr_in),
		.pop(hdr_pop), .dout(hdr_out), .empty(hdr_empty), .full()
	);

	wb_readout u_wb (
		.WRCLK(WRCLK), .srst(srst), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
		.wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
		.rd_gnt(rd_gnt), .rd_data(rd_data), .hdr_out(hdr_out),
		.hdr_empty(hdr_empty), .buf_busy(buf_busy), .wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack), .rd_req(rd_req), .rd_addr(rd_addr),
		.hdr_pop(hdr_pop), .rel(rel), .rel_buf(rel_buf)
	);

endmodule

//--- tb_sample_buffer.sv
`timescale 1ns/1ns
`include "daq_cfg.svh"

module tb_sample_buffer import daq_pkg::*;;

	// about 1536 sample reads at 5 to 8 cycles each plus four short events
	localparam int MAX_CYCLES = 20000;

	logic                  WRCLK;
	logic                  srst;
	logic                  l1a;
	logic                  l1a_match;
	logic                  adc_valid;
	group_t                adc_g1, adc_g2, adc_g3, adc_g4, adc_g5, adc_g6;
	smp_cnt_t              samp_max;
	logic                  wb_cyc;
	logic                  wb_stb;
	logic                  wb_we;
	logic [`DAQ_WB_AW-1:0] wb_adr;
	wb_dat_t               wb_dat_w;
	wb_dat_t               wb_dat_r;
	logic                  wb_ack;

	integer    seed;
	int        cycles;
	l1a_cnt_t  l1a_total;       // l1a pulses driven so far
	mtch_cnt_t mtch_total;
	group_t    model [2][8][`DAQ_NGRP];   // expected words per half
	header_t   hdr [3];

	sample_buffer_top DUT (.*);

	initial WRCLK = 1'b0;
	always #10 WRCLK = ~WRCLK;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic value_error(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		stop_run($sformatf("error at %0t ns: %s expected %0h actual %0h",
			$time, name, exp, act));
	endtask

	always @(posedge WRCLK) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES)
			stop_run("timeout: the run did not finish within the cycle limit");
	end

	// ack may only show while a transfer is held, so it lasts one cycle
	always @(negedge WRCLK) begin
		assert (!(wb_ack && !wb_stb))
			else stop_run("wb_ack was high with no transfer in progress");
	end

	////////////////////////////////////////
	// wishbone master
	task automatic wb_access(input logic we, input logic [15:0] adr,
		input wb_dat_t dat_w, output wb_dat_t dat_r);
		int lat;
		lat = 0;
		@(posedge WRCLK);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= dat_w;
		@(negedge WRCLK);
		while (!wb_ack) begin
			@(negedge WRCLK);
			lat++;
		end
		dat_r = wb_dat_r;
		@(posedge WRCLK);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		if (adr[15:14] == 2'b01) begin
			assert (lat == 1) else value_error("wb_ack latency", 64'(1), 64'(lat));
		end else begin
			assert (lat >= 3) else stop_run("wb_ack came too early on a sample read");
		end
	endtask

	task automatic check_status(input wb_dat_t exp);
		wb_dat_t rd;
		wb_access(1'b0, 16'h4000, '0, rd);
		assert (rd == exp) else value_error("wb_dat_r (status)", 64'(exp), 64'(rd));
	endtask

	task automatic check_header(input header_t exp);
		logic [47:0] ext;
		wb_dat_t     rd;
		ext = {5'b0, exp};
		for (int r = 1; r <= 3; r++) begin
			wb_access(1'b0, 16'h4000 + 16'(r), '0, rd);
			assert (rd == ext[(r-1)*16 +: 16])
				else value_error($sformatf("wb_dat_r (header reg %0d)", r),
					64'(ext[(r-1)*16 +: 16]), 64'(rd));
		end
	endtask

	task automatic pop_header();
		wb_dat_t rd;
		wb_access(1'b1, 16'h4004, 16'h0001, rd);
	endtask

	// every channel of every word of one half
	task automatic read_buffer(input logic b, input int smax);
		ram_addr_t ra;
		group_t    w;
		wb_dat_t   rd;
		sample_t   exp;
		for (int s = 0; s <= smax; s++)
			for (int g = 0; g < `DAQ_NGRP; g++)
				for (int ch = 0; ch < `DAQ_NCH; ch++) begin
					ra  = {b, 9'(s * `DAQ_NGRP + g)};
					w   = model[b][s][g];
					exp = w[ch*`DAQ_CH_W +: `DAQ_CH_W];
					wb_access(1'b0, {2'b00, ra, 4'(ch)}, '0, rd);
					assert (rd == {4'b0, exp})
						else value_error($sformatf("wb_dat_r (buf %0d s %0d g %0d ch %0d)",
							b, s, g, ch), 64'(exp), 64'(rd));
				end
	endtask

	////////////////////////////////////////
	// trigger and frame stimulus
	task automatic pulse(input logic a, input logic m);
		@(posedge WRCLK);
		l1a       <= a;
		l1a_match <= m;
		@(posedge WRCLK);
		l1a       <= 1'b0;
		l1a_match <= 1'b0;
		if (a)
			l1a_total = l1a_total + 1'b1;
		if (m)
			mtch_total = mtch_total + 1'b1;
	endtask

	// one event into half b, n_ovlp extra matches after the second frame
	task automatic run_event(input logic b, input int smax, input int n_ovlp,
		output header_t h);
		group_t    frame [`DAQ_NGRP];
		l1a_cnt_t  l1a_snap;
		mtch_cnt_t mtch_snap;
		int        n;
		@(posedge WRCLK);
		samp_max <= smp_cnt_t'(smax);
		pulse(1'b1, 1'b0);          // lone trigger, no match
		pulse(1'b1, 1'b1);
		l1a_snap  = l1a_total;
		mtch_snap = mtch_total;
		for (int s = 0; s <= smax; s++) begin
			for (int g = 0; g < `DAQ_NGRP; g++) begin
				for (int k = 0; k < 6; k++)
					frame[g][k*32 +: 32] = $random(seed);
				model[b][s][g] = frame[g];
			end
			@(posedge WRCLK);
			adc_valid <= 1'b1;
			adc_g1    <= frame[0];
			adc_g2    <= frame[1];
			adc_g3    <= frame[2];
			adc_g4    <= frame[3];
			adc_g5    <= frame[4];
			adc_g6    <= frame[5];
			@(posedge WRCLK);
			adc_valid <= 1'b0;
			n = (s == 1) ? n_ovlp : 0;
			repeat (n) pulse(1'b1, 1'b1);
			repeat (6 - 2 * n) @(posedge WRCLK);   // 8 cycles per frame
		end
		repeat (4) @(posedge WRCLK);   // header lands 1 cycle after done
		h = {b, n_ovlp > 1, n_ovlp != 0, ovlp_cnt_t'(n_ovlp), mtch_snap, l1a_snap};
	endtask

	initial begin
		seed       = 32'h888fdd42;
		cycles     = 0;
		l1a_total  = '0;
		mtch_total = '0;
		srst       = 1'b1;
		l1a        = 1'b0;
		l1a_match  = 1'b0;
		adc_valid  = 1'b0;
		{adc_g1, adc_g2, adc_g3, adc_g4, adc_g5, adc_g6} = '0;
		samp_max   = '0;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_w   = '0;
		repeat (16) @(posedge WRCLK);
		srst <= 1'b0;
		repeat (2) @(posedge WRCLK);

		check_status(16'h0001);     // fifo empty, both halves free
		run_event(1'b0, 3, 2, hdr[0]);
		check_status(16'h0002);
		check_header(hdr[0]);

		// readout of half 0 competes with the loader
		fork
			run_event(1'b1, 7, 1, hdr[1]);
			read_buffer(1'b0, 3);
		join
		check_status(16'h0006);
		check_header(hdr[0]);

		pulse(1'b1, 1'b1);          // both halves busy so this one drops
		repeat (8) @(posedge WRCLK);
		check_status(16'h0006);
		check_header(hdr[0]);

		pop_header();               // frees half 0
		check_status(16'h0004);
		check_header(hdr[1]);
		fork
			run_event(1'b0, 3, 0, hdr[2]);
			read_buffer(1'b1, 7);
		join
		check_status(16'h0006);

		pop_header();
		check_status(16'h0002);
		check_header(hdr[2]);
		read_buffer(1'b0, 3);
		pop_header();
		check_status(16'h0001);     // no stray headers left

		$display("test passed");
		$finish;
	end

endmodule

//--- all.f
+incdir+.
daq_pkg.sv
event_control.sv
frame_loader.sv
sample_ram.sv
ram_arbiter.sv
header_fifo.sv
wb_readout.sv
sample_buffer_top.sv
tb_sample_buffer.sv

//--- Makefile
# Verilator build and run for the sample buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_sample_buffer
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
SIM_ARGS  ?=

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)
